//--- include/rx_config.svh
/* sizes for the receive chain. parallel samples times sample width must be 32,
   and the timestamp must fit the 32-bit readout word */
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// physical and logical channel count
`define RX_CHANNELS 2

// samples per adc word, per channel
`define RX_PARALLEL_SAMPLES 2
`define RX_SAMPLE_WIDTH 16

// entries per capture bank
`define RX_BANK_DEPTH 16

// word index width
`define RX_TSTAMP_WIDTH 32

// readout stream width
`define RX_READ_WIDTH 32

`endif

//--- rtl/rx_sample_pkg.sv
/* payload types of the receive chain, sized from rx_config.svh */
`include "rx_config.svh"

package rx_sample_pkg;

  // mux source index covers C physical plus C derivative sources
  localparam int SEL_WIDTH = $clog2(2 * `RX_CHANNELS);

  // one signed adc sample
  typedef logic signed [`RX_SAMPLE_WIDTH-1:0] sample_t;

  // parallel samples of one channel, sample 0 in the low bits
  typedef sample_t [`RX_PARALLEL_SAMPLES-1:0] word_t;

  // index of a word since start
  typedef logic [`RX_TSTAMP_WIDTH-1:0] tstamp_t;

  // 0..C-1 physical channel, C..2C-1 derivative of that channel
  typedef logic [SEL_WIDTH-1:0] src_sel_t;

  typedef logic [`RX_READ_WIDTH-1:0] read_t; // readout stream word

endpackage

//--- rtl/rx_ctrl_pkg.sv
/* control types: capture states, readout phases and the register map.
   channel thresholds occupy ADDR_THRESH0 up to ADDR_THRESH0 + C - 1 */
package rx_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,     // waiting for start
    CAPTURE,  // storing kept words
    DRAIN     // streaming banks out
  } capture_state_t;

  typedef enum logic [1:0] {
    COUNT,    // number of kept entries
    TSTAMP,   // one index per entry
    DATA      // one word per entry
  } read_phase_t;

  typedef logic [3:0] reg_addr_t;

  ////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////
  localparam reg_addr_t ADDR_THRESH0 = 4'h0; // plus channel number
  localparam reg_addr_t ADDR_MUX     = 4'h8; // packed selects, channel 0 low
  localparam reg_addr_t ADDR_CTRL    = 4'h9; // bit 0 start, bit 1 stop

endpackage

//--- rtl/rx_config_decode.sv
/* register write decode. writes to unmapped addresses are dropped;
   start and stop come out as single-cycle pulses one cycle after the write */
`include "rx_config.svh"

module rx_config_decode
  import rx_sample_pkg::*;
  import rx_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      cfg_valid,
  input  reg_addr_t cfg_addr,
  input  logic [31:0] cfg_data,
  input  logic      start_aux,
  output sample_t   thresh [`RX_CHANNELS],
  output src_sel_t  mux_sel [`RX_CHANNELS],
  output logic      start,
  output logic      stop
);

  localparam int C = `RX_CHANNELS;

  logic ctrl_wr;     // write to the control register
  logic start_aux_q; // for edge detect on the aux trigger

  assign ctrl_wr = cfg_valid && (cfg_addr == ADDR_CTRL);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < C; i++) begin
        thresh[i]  <= '0;
        mux_sel[i] <= src_sel_t'(i); // logical i passes physical i
      end
      start       <= 1'b0;
      stop        <= 1'b0;
      start_aux_q <= 1'b0;
    end else begin
      start_aux_q <= start_aux;
      start <= (ctrl_wr && cfg_data[0]) || (start_aux && !start_aux_q);
      stop  <= ctrl_wr && cfg_data[1];
      if (cfg_valid) begin
        for (int i = 0; i < C; i++) begin
          if (cfg_addr == ADDR_THRESH0 + reg_addr_t'(i)) begin
            thresh[i] <= cfg_data[`RX_SAMPLE_WIDTH-1:0];
          end
          if (cfg_addr == ADDR_MUX) begin
            mux_sel[i] <= cfg_data[i*SEL_WIDTH +: SEL_WIDTH];
          end
        end
      end
    end
  end

  // selects must name a real source in the mux
  for (genvar i = 0; i < C; i++) begin : g_sel_chk
    assert property (@(posedge clk) disable iff (!arst_n) int'(mux_sel[i]) < 2 * C);
  end

endmodule

//--- rtl/sample_differentiator.sv
/* first difference of one channel, one cycle of latency.
   the difference wraps at the sample width; history survives a new capture */
`include "rx_config.svh"

module sample_differentiator
  import rx_sample_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  in_valid,
  input  word_t in_data,
  output logic  out_valid,
  output word_t out_data,
  output word_t raw_data
);

  localparam int P = `RX_PARALLEL_SAMPLES;

  sample_t prev_sample; // last sample of the previous valid word

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid   <= 1'b0;
      prev_sample <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) prev_sample <= in_data[P-1];
    end
  end

  // payload path
  always_ff @(posedge clk) begin
    if (in_valid) begin
      raw_data    <= in_data; // keeps raw aligned with the derivative
      out_data[0] <= in_data[0] - prev_sample; // across the word boundary
      for (int i = 1; i < P; i++) begin
        out_data[i] <= in_data[i] - in_data[i-1];
      end
    end
  end

endmodule

//--- rtl/channel_mux.sv
/* registered source select per logical channel, one cycle of latency.
   all sources share one valid, so a single strobe comes out */
`include "rx_config.svh"

module channel_mux
  import rx_sample_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     src_valid,
  input  word_t    src_data [2*`RX_CHANNELS],
  input  src_sel_t sel [`RX_CHANNELS],
  output logic     chan_valid,
  output word_t    chan_data [`RX_CHANNELS]
);

  localparam int C = `RX_CHANNELS;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      chan_valid <= 1'b0;
    end else begin
      chan_valid <= src_valid;
    end
  end

  // low half physical, high half derivative
  always_ff @(posedge clk) begin
    if (src_valid) begin
      for (int c = 0; c < C; c++) begin
        chan_data[c] <= src_data[sel[c]];
      end
    end
  end

endmodule

//--- rtl/sample_discriminator.sv
/* combinational keep flag per channel, signed compare, strictly above.
   no hysteresis: every word is judged on its own */
`include "rx_config.svh"

module sample_discriminator
  import rx_sample_pkg::*;
(
  input  logic    chan_valid,
  input  word_t   chan_data [`RX_CHANNELS],
  input  sample_t thresh [`RX_CHANNELS],
  output logic [`RX_CHANNELS-1:0] keep
);

  localparam int C = `RX_CHANNELS;
  localparam int P = `RX_PARALLEL_SAMPLES;

  always_comb begin
    keep = '0;
    for (int c = 0; c < C; c++) begin
      for (int s = 0; s < P; s++) begin
        // any sample over threshold marks the whole word
        if (chan_valid && ($signed(chan_data[c][s]) > thresh[c])) begin
          keep[c] = 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/capture_bank.sv
/* append-only storage with a saturating count; clear resets the count only.
   read data is registered, so rd_addr must be held a cycle before use */
`include "rx_config.svh"

module capture_bank #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = `RX_BANK_DEPTH,
  localparam int AW        = $clog2(DEPTH),
  localparam int CW        = $clog2(DEPTH + 1)
) (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          clear,
  input  logic          wr_en,
  input  payload_t      wr_data,
  input  logic [AW-1:0] rd_addr,
  output payload_t      rd_data,
  output logic [CW-1:0] count,
  output logic          full
);

  payload_t mem [DEPTH];
  logic     do_wr;

  assign full  = (count == CW'(DEPTH));
  assign do_wr = wr_en && !full && !clear;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (do_wr) begin
      count <= count + 1'b1; // stops at DEPTH
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[count[AW-1:0]] <= wr_data;
    rd_data <= mem[rd_addr];
  end

  // the owner gates writes with full
  assert property (@(posedge clk) disable iff (!arst_n) full |-> !wr_en);

endmodule

//--- rtl/capture_readout.sv
/* capture FSM, word index, per-channel banks and the readout stream.
   words in flight at stop are dropped; one readout word every two cycles at best */
`include "rx_config.svh"

module capture_readout
  import rx_sample_pkg::*;
  import rx_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  start,
  input  logic  stop,
  input  logic  chan_valid,
  input  word_t chan_data [`RX_CHANNELS],
  input  logic [`RX_CHANNELS-1:0] keep,
  input  logic  dma_ready,
  output logic  dma_valid,
  output read_t dma_data,
  output logic  dma_last,
  output logic  busy
);

  localparam int C   = `RX_CHANNELS;
  localparam int AW  = $clog2(`RX_BANK_DEPTH);
  localparam int CW  = $clog2(`RX_BANK_DEPTH + 1);
  localparam int CHW = (C > 1) ? $clog2(C) : 1;

  capture_state_t state;
  tstamp_t        word_idx;   // counts chan_valid in CAPTURE
  logic           bank_clear;
  logic [C-1:0]   bank_wr;
  word_t          d_rd [C];
  tstamp_t        t_rd [C];
  logic [CW-1:0]  d_cnt [C];
  logic [C-1:0]   d_full;
  logic [C-1:0]   t_full;

  logic [CHW-1:0] rd_ch;      // channel being read out
  read_phase_t    phase;
  logic [CW-1:0]  entry;      // entry within the phase
  logic           primed;     // bank read data matches entry
  logic           load;
  logic [CW-1:0]  cur_cnt;
  logic           ch_end;
  logic           last_word;
  read_t          next_word;

  assign busy       = (state != IDLE);
  assign bank_clear = (state == IDLE) && start;

  ////////////////////////////////////////////////////////////////////
  // capture
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      word_idx <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state    <= CAPTURE;
            word_idx <= '0;
          end
        end
        CAPTURE: begin
          if (chan_valid) word_idx <= word_idx + 1'b1; // advances even when full
          if (stop) state <= DRAIN;
        end
        DRAIN: begin
          if (dma_valid && dma_ready && dma_last) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  for (genvar i = 0; i < C; i++) begin : g_bank
    assign bank_wr[i] = (state == CAPTURE) && keep[i] && !d_full[i] && !t_full[i];

    capture_bank #(.payload_t(word_t)) i_data_bank (
      .clk,
      .arst_n,
      .clear   (bank_clear),
      .wr_en   (bank_wr[i]),
      .wr_data (chan_data[i]),
      .rd_addr (entry[AW-1:0]),
      .rd_data (d_rd[i]),
      .count   (d_cnt[i]),
      .full    (d_full[i])
    );

    // same fill as the data bank, so its count is not needed
    capture_bank #(.payload_t(tstamp_t)) i_tstamp_bank (
      .clk,
      .arst_n,
      .clear   (bank_clear),
      .wr_en   (bank_wr[i]),
      .wr_data (word_idx),   // index the word arrived with
      .rd_addr (entry[AW-1:0]),
      .rd_data (t_rd[i]),
      .count   (),
      .full    (t_full[i])
    );
  end

  ////////////////////////////////////////////////////////////////////
  // readout sequencing
  ////////////////////////////////////////////////////////////////////
  assign cur_cnt   = d_cnt[rd_ch];
  assign ch_end    = ((phase == COUNT) && (cur_cnt == '0))
                  || ((phase == DATA) && (entry + 1'b1 == cur_cnt));
  assign last_word = ch_end && (rd_ch == CHW'(C - 1));
  // output slot free or being emptied, and never past the final word
  assign load = (state == DRAIN) && primed && (!dma_valid || (dma_ready && !dma_last));

  always_comb begin
    case (phase)
      COUNT:   next_word = read_t'(cur_cnt);
      TSTAMP:  next_word = read_t'(t_rd[rd_ch]);
      DATA:    next_word = read_t'(d_rd[rd_ch]);
      default: next_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ch     <= '0;
      phase     <= COUNT;
      entry     <= '0;
      primed    <= 1'b0;
      dma_valid <= 1'b0;
      dma_last  <= 1'b0;
    end else if (state != DRAIN) begin
      rd_ch     <= '0; // ready for the next drain
      phase     <= COUNT;
      entry     <= '0;
      primed    <= 1'b0;
      dma_valid <= 1'b0;
      dma_last  <= 1'b0;
    end else begin
      primed <= !load; // one cycle for the bank read after entry moves
      if (load) begin
        dma_valid <= 1'b1;
        dma_last  <= last_word;
        if (ch_end) begin
          rd_ch <= rd_ch + 1'b1;
          phase <= COUNT;
          entry <= '0;
        end else if (phase == COUNT) begin
          phase <= TSTAMP; // entry already 0
        end else if ((phase == TSTAMP) && (entry + 1'b1 == cur_cnt)) begin
          phase <= DATA;
          entry <= '0;
        end else begin
          entry <= entry + 1'b1;
        end
      end else if (dma_ready) begin
        dma_valid <= 1'b0;
        dma_last  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) dma_data <= next_word;
  end

  // a stalled word holds until taken
  assert property (@(posedge clk) disable iff (!arst_n)
    dma_valid && !dma_ready |=> dma_valid && $stable(dma_data) && $stable(dma_last));

endmodule

//--- rtl/receive_top.sv
/* receive slice: decode, differentiate, mux, discriminate, capture, drain.
   single clock domain; the adc valid is shared by all channels */
`include "rx_config.svh"

module receive_top
  import rx_sample_pkg::*;
  import rx_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        adc_valid,
  input  word_t       adc_data [`RX_CHANNELS],
  input  logic        start_aux,  // trigger from the transmit side
  input  logic        cfg_valid,
  input  reg_addr_t   cfg_addr,
  input  logic [31:0] cfg_data,
  input  logic        dma_ready,
  output logic        dma_valid,
  output read_t       dma_data,
  output logic        dma_last,
  output logic        busy
);

  localparam int C = `RX_CHANNELS;

  sample_t      thresh [C];
  src_sel_t     mux_sel [C];
  logic         start, stop;
  logic [C-1:0] diff_valid;
  word_t        mux_src [2*C];   // physical low, derivative high
  logic         chan_valid;
  word_t        chan_data [C];
  logic [C-1:0] keep;

  ////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////
  rx_config_decode i_decode (
    .clk, .arst_n, .cfg_valid, .cfg_addr, .cfg_data, .start_aux,
    .thresh, .mux_sel, .start, .stop
  );

  ////////////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < C; i++) begin : g_diff
    sample_differentiator i_diff (
      .clk, .arst_n,
      .in_valid  (adc_valid),
      .in_data   (adc_data[i]),
      .out_valid (diff_valid[i]),
      .out_data  (mux_src[C + i]),
      .raw_data  (mux_src[i])    // raw delayed to match
    );
  end

  channel_mux i_mux (
    .clk, .arst_n,
    .src_valid (&diff_valid),    // identical strobes
    .src_data  (mux_src),
    .sel       (mux_sel),
    .chan_valid, .chan_data
  );

  sample_discriminator i_disc (.chan_valid, .chan_data, .thresh, .keep);

  // result
  capture_readout i_readout (
    .clk, .arst_n, .start, .stop, .chan_valid, .chan_data, .keep,
    .dma_ready, .dma_valid, .dma_data, .dma_last, .busy
  );

endmodule

//--- bench/receive_tb.sv
/* self-checking testbench for receive_top. the model replays every adc word since reset,
   so the differentiator history is exact; stimulus stays idle while a drain runs */
`include "rx_config.svh"

module receive_tb
  import rx_sample_pkg::*;
  import rx_ctrl_pkg::*;
();

  localparam int C     = `RX_CHANNELS;
  localparam int P     = `RX_PARALLEL_SAMPLES;
  localparam int SW    = `RX_SAMPLE_WIDTH;
  localparam int DEPTH = `RX_BANK_DEPTH;

  logic        clk;
  logic        arst_n;
  logic        adc_valid;
  word_t       adc_data [C];
  logic        start_aux;
  logic        cfg_valid;
  reg_addr_t   cfg_addr;
  logic [31:0] cfg_data;
  logic        dma_ready;
  logic        dma_valid;
  read_t       dma_data;
  logic        dma_last;
  logic        busy;

  integer  seed = 38381;
  int      checks = 0;
  int      errors = 0;
  int      timeouts = 0;
  word_t   hist [$];     // every word sent since reset with C entries per word
  read_t   exp_q [$];    // expected readout stream
  read_t   exp_word;
  int      sel_m [C];    // model copy of the mux selects
  sample_t thr_m [C];    // model copy of the thresholds
  int      cap_first;    // first word of the current capture
  bit      rand_ready;

  receive_top i_dut (
    .clk, .arst_n, .adc_valid, .adc_data, .start_aux,
    .cfg_valid, .cfg_addr, .cfg_data, .dma_ready,
    .dma_valid, .dma_data, .dma_last, .busy
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // sink back-pressure is random only while a drain runs
  always @(posedge clk) begin : ready_drive
    bit rand_now;
    rand_now = rand_ready; // mode as it stood before this edge
    #1;
    if (rand_now) dma_ready = (($random(seed) & 3) != 0);
    else dma_ready = 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////
  function automatic word_t source_word(int n, int sel);
    word_t   cur;
    word_t   r;
    sample_t prev;
    if (sel < C) return hist[n*C + sel]; // physical channel
    cur  = hist[n*C + sel - C];
    prev = (n == 0) ? sample_t'(0) : hist[(n-1)*C + sel - C][P-1];
    for (int s = 0; s < P; s++) begin
      r[s] = cur[s] - prev; // wraps at the sample width
      prev = cur[s];
    end
    return r;
  endfunction

  function automatic bit word_kept(word_t w, sample_t thr);
    bit hit = 1'b0;
    for (int s = 0; s < P; s++) begin
      if ($signed(w[s]) > $signed(thr)) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic void build_expected();
    word_t   kd [C][DEPTH];
    tstamp_t kt [C][DEPTH];
    int      cnt [C];
    word_t   w;
    exp_q.delete();
    for (int c = 0; c < C; c++) cnt[c] = 0;
    for (int n = cap_first; n < hist.size() / C; n++) begin
      for (int c = 0; c < C; c++) begin
        w = source_word(n, sel_m[c]);
        if (word_kept(w, thr_m[c]) && (cnt[c] < DEPTH)) begin // full bank drops
          kd[c][cnt[c]] = w;
          kt[c][cnt[c]] = tstamp_t'(n - cap_first); // index since start
          cnt[c]++;
        end
      end
    end
    for (int c = 0; c < C; c++) begin
      exp_q.push_back(read_t'(cnt[c]));
      for (int i = 0; i < cnt[c]; i++) exp_q.push_back(read_t'(kt[c][i]));
      for (int i = 0; i < cnt[c]; i++) exp_q.push_back(read_t'(kd[c][i]));
    end
  endfunction

  // channel c selects source (offset + c) mod 2C
  function automatic logic [31:0] sel_word(int offset);
    logic [31:0] d = '0;
    for (int c = 0; c < C; c++) begin
      d[c*SEL_WIDTH +: SEL_WIDTH] = SEL_WIDTH'((offset + c) % (2 * C));
    end
    return d;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // comparator
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (arst_n && dma_valid && dma_ready) begin
      checks++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("readout word %h at %0t was not expected", dma_data, $time);
      end else begin
        exp_word = exp_q.pop_front();
        if (dma_data !== exp_word) begin
          errors++;
          $display("error at %0t: dma_data expected %h, got %h", $time, exp_word, dma_data);
        end
        if (dma_last !== (exp_q.size() == 0)) begin
          errors++;
          $display("error at %0t: dma_last expected %b, got %b", $time,
                   exp_q.size() == 0, dma_last);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic end_run();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, got);
    end
  endtask

  task automatic do_reset();
    arst_n = 1'b0;
    hist.delete();
    exp_q.delete();
    for (int c = 0; c < C; c++) begin
      sel_m[c] = c; // logical i passes physical i
      thr_m[c] = '0;
    end
    repeat (10) tick();
    arst_n = 1'b1;
    tick();
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
    cfg_valid = 1'b1;
    cfg_addr  = addr;
    cfg_data  = data;
    for (int c = 0; c < C; c++) begin
      if (addr == ADDR_MUX) sel_m[c] = int'(data[c*SEL_WIDTH +: SEL_WIDTH]);
      if (addr == ADDR_THRESH0 + reg_addr_t'(c)) thr_m[c] = data[SW-1:0];
    end
    tick();
    cfg_valid = 1'b0;
  endtask

  task automatic wait_busy(input logic level, input int limit);
    int n = 0;
    while (busy !== level) begin
      if (n == limit) begin
        timeouts++;
        $display("busy did not reach %b within %0d cycles", level, limit);
        end_run();
      end
      n++;
      tick();
    end
  endtask

  // mode 0 ramp, 1 random, 2 random positive
  task automatic send_words(input int count, input int mode, input bit gaps);
    word_t w;
    int    gap;
    for (int k = 0; k < count; k++) begin
      for (int c = 0; c < C; c++) begin
        for (int s = 0; s < P; s++) begin
          case (mode)
            0:       w[s] = sample_t'(1 + 64*c + 3*(k*P + s));
            1:       w[s] = sample_t'($random(seed));
            default: w[s] = sample_t'(($random(seed) & 16'h7fff) | 1);
          endcase
        end
        adc_data[c] = w;
        hist.push_back(w);
      end
      adc_valid = 1'b1;
      tick();
      adc_valid = 1'b0;
      if (gaps) begin
        gap = $random(seed) & 3;
        repeat (gap) tick();
      end
    end
  endtask

  task automatic start_capture();
    write_reg(ADDR_CTRL, 32'h1);
    wait_busy(1'b1, 20);
    cap_first = hist.size() / C;
  endtask

  task automatic finish_capture(input bit rand_rdy);
    repeat (4) tick(); // adc to bank takes 3 edges
    build_expected();
    write_reg(ADDR_CTRL, 32'h2);
    rand_ready = rand_rdy;
    wait_busy(1'b0, 4000);
    rand_ready = 1'b0;
    if (exp_q.size() != 0) begin
      errors++;
      $display("readout ended with %0d expected words not delivered", exp_q.size());
    end
  endtask

  task automatic run_capture(input int count, input int mode, input bit gaps,
                             input bit rand_rdy);
    start_capture();
    send_words(count, mode, gaps);
    finish_capture(rand_rdy);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    arst_n     = 1'b0;
    adc_valid  = 1'b0;
    start_aux  = 1'b0;
    cfg_valid  = 1'b0;
    cfg_addr   = '0;
    cfg_data   = '0;
    dma_ready  = 1'b1;
    rand_ready = 1'b0;
    cap_first  = 0;
    for (int c = 0; c < C; c++) adc_data[c] = '0;
    do_reset();

    // reset values, then raw ramp through the default mux
    check_bit("dma_valid", dma_valid, 1'b0);
    check_bit("dma_last", dma_last, 1'b0);
    check_bit("busy", busy, 1'b0);
    run_capture(6, 0, 1'b0, 1'b0);

    // derivatives from reset, so word 0 differs against zero
    do_reset();
    for (int c = 0; c < C; c++) write_reg(ADDR_THRESH0 + reg_addr_t'(c), 32'h8000);
    write_reg(ADDR_MUX, sel_word(C));
    run_capture(8, 0, 1'b0, 1'b0);

    // mixed sources, per-channel thresholds, gaps between words
    write_reg(ADDR_MUX, sel_word(1));
    write_reg(ADDR_THRESH0, 32'h4000);
    write_reg(ADDR_THRESH0 + reg_addr_t'(1), 32'h0100);
    run_capture(20, 1, 1'b1, 1'b0);

    // more kept words than a bank holds
    write_reg(ADDR_MUX, sel_word(0));
    write_reg(ADDR_THRESH0, 32'h0);
    write_reg(ADDR_THRESH0 + reg_addr_t'(1), 32'h0);
    run_capture(20, 2, 1'b0, 1'b0);

    // random back-pressure on the readout
    write_reg(ADDR_THRESH0 + reg_addr_t'(1), 32'hc000);
    run_capture(14, 1, 1'b1, 1'b1);

    // aux start inside CAPTURE keeps the banks
    write_reg(ADDR_THRESH0 + reg_addr_t'(1), 32'h0);
    start_capture();
    send_words(4, 2, 1'b0);
    start_aux = 1'b1;
    tick();
    start_aux = 1'b0;
    send_words(4, 2, 1'b0);
    finish_capture(1'b0);

    // stop while idle must not start a drain
    write_reg(ADDR_CTRL, 32'h2);
    repeat (10) begin
      check_bit("busy", busy, 1'b0);
      check_bit("dma_valid", dma_valid, 1'b0);
      tick();
    end

    end_run();
  end

endmodule

//--- flist.f
+incdir+include
rtl/rx_sample_pkg.sv
rtl/rx_ctrl_pkg.sv
rtl/rx_config_decode.sv
rtl/sample_differentiator.sv
rtl/channel_mux.sv
rtl/sample_discriminator.sv
rtl/capture_bank.sv
rtl/capture_readout.sv
rtl/receive_top.sv
bench/receive_tb.sv

//--- Bender.yml
package:
  name: receive_slice

export_include_dirs:
  - include

sources:
  - files:
      - rtl/rx_sample_pkg.sv
      - rtl/rx_ctrl_pkg.sv
      - rtl/rx_config_decode.sv
      - rtl/sample_differentiator.sv
      - rtl/channel_mux.sv
      - rtl/sample_discriminator.sv
      - rtl/capture_bank.sv
      - rtl/capture_readout.sv
      - rtl/receive_top.sv
  - target: simulation
    files:
      - bench/receive_tb.sv
